/* Bender.yml */
package:
  name: tinyqv

sources:
  - rtl/tinyqv_pkg.sv
  - rtl/tinyqv_decoder.sv
  - rtl/tinyqv_alu.sv
  - rtl/tinyqv_regfile.sv
  - rtl/tinyqv_prefetch.sv
  - rtl/tinyqv_mem_arbiter.sv
  - rtl/tinyqv_core.sv
  - rtl/tinyqv_top.sv
  - target: simulation
    files:
      - dv/tinyqv_chk.sv
      - dv/tb_tinyqv.sv

/* build.f */
rtl/tinyqv_pkg.sv
rtl/tinyqv_decoder.sv
rtl/tinyqv_alu.sv
rtl/tinyqv_regfile.sv
rtl/tinyqv_prefetch.sv
rtl/tinyqv_mem_arbiter.sv
rtl/tinyqv_core.sv
rtl/tinyqv_top.sv
dv/tinyqv_chk.sv
dv/tb_tinyqv.sv

/* dv/tb_tinyqv.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tinyqv;
    import tinyqv_pkg::*;

    logic        clk;
    logic        rst_n = 1'b0;
    mem_req_t    mem_req;
    logic [31:0] mem_rdata = 32'b0;
    logic        halted;
    logic        illegal;

    logic [31:0] mem [0:255];
    logic [31:0] image [0:255];     // copied into mem while rst_n is low
    logic [31:0] regs [0:15];       // register values the program should produce
    logic        exp_valid [0:255];
    logic [31:0] exp_data [0:255];
    string       exp_name [0:255];
    logic [31:0] pc;
    logic [31:0] daddr;             // next store address
    logic [7:0]  idx;
    int          seed;
    int          n_expected = 0;
    int          n_seen = 0;
    int          value_errs = 0;
    int          monitor_errs = 0;
    int          check_errs = 0;

    tinyqv_top tinyqv_top_inst (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_rdata(mem_rdata),
        .halted(halted), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory model with one cycle read latency
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];
            end
        end else begin
            if (mem_req.write) mem[mem_req.addr[9:2]] <= mem_req.wdata;
            if (mem_req.read)  mem_rdata <= mem[mem_req.addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (rst_n && mem_req.write) begin
            idx = mem_req.addr[9:2];
            assert (exp_valid[idx]) else begin
                $display("store to %h that the program should never reach", mem_req.addr);
                monitor_errs++;
            end
            if (exp_valid[idx]) begin
                n_seen++;
                assert (mem_req.wdata == exp_data[idx]) else begin
                    $display("ERR %s expected %h actual %h", exp_name[idx], exp_data[idx],
                             mem_req.wdata);
                    value_errs++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!mem_req.read && !mem_req.write && !halted && !illegal) else begin
                $display("bus strobe or status output high during reset");
                monitor_errs++;
            end
        end
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        image[pc[9:2]] = word;
        pc = pc + 32'd4;
    endtask

    task automatic fill_image();
        for (int i = 0; i < 256; i++) begin
            image[i]     = {8'h5a, 8'(i), ~8'(i), 8'(i * 7)};
            exp_valid[i] = 1'b0;
        end
    endtask

    task automatic load_imm(input int rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = val + 32'h800;   // addi sign-extends its low 12 bits
        emit({upper[31:12], 5'(rd), 7'b0110111});
        emit({val[11:0], 5'(rd), 3'b000, 5'(rd), 7'b0010011});
        regs[rd] = val;
    endtask

    // sw rs2, daddr(x0)
    task automatic store(input int rs2, input string name, input logic expect_it);
        emit({daddr[11:5], 5'(rs2), 5'd0, 3'b010, daddr[4:0], 7'b0100011});
        if (expect_it) begin
            exp_valid[daddr[9:2]] = 1'b1;
            exp_data[daddr[9:2]]  = regs[rs2];
            exp_name[daddr[9:2]]  = name;
            n_expected++;
        end
        daddr = daddr + 32'd4;
    endtask

    task automatic check_rr(input logic [2:0] f3, input logic alt, input int rs1,
                            input int rs2, input string name);
        emit({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'd6, 7'b0110011});
        regs[6] = alu_ref(f3, alt, regs[rs1], regs[rs2]);
        store(6, name, 1'b1);
    endtask

    task automatic check_ri(input logic [2:0] f3, input int rs1, input logic [11:0] imm,
                            input string name);
        emit({imm, 5'(rs1), f3, 5'd7, 7'b0010011});
        regs[7] = alu_ref(f3, f3 == 3'd5 && imm[10], regs[rs1], {{20{imm[11]}}, imm});
        store(7, name, 1'b1);
    endtask

    task automatic check_branch(input logic [2:0] f3, input int rs1, input int rs2,
                                input string name);
        logic taken;
        taken = branch_ref(f3, regs[rs1], regs[rs2]);
        emit({7'b0, 5'(rs2), 5'(rs1), f3, 5'b01000, 7'b1100011});  // +8 skips the marker
        store(10, name, !taken);
    endtask

    task automatic assemble_main();
        logic [19:0] upper;
        for (int i = 0; i < 16; i++) begin
            regs[i] = 32'b0;
        end
        fill_image();
        pc    = reset_pc;
        daddr = 32'h200;
        load_imm(1, $random(seed));
        load_imm(2, $random(seed));
        load_imm(3, 32'h8000_0000);
        load_imm(4, 32'h7fff_ffff);
        load_imm(5, $random(seed));
        load_imm(10, $random(seed));
        check_rr(3'd0, 1'b0, 1, 2, "add");
        check_rr(3'd0, 1'b1, 1, 2, "sub");
        check_rr(3'd1, 1'b0, 1, 5, "sll");
        check_rr(3'd2, 1'b0, 3, 4, "slt min max");
        check_rr(3'd2, 1'b0, 4, 3, "slt max min");
        check_rr(3'd3, 1'b0, 3, 4, "sltu min max");
        check_rr(3'd3, 1'b0, 4, 3, "sltu max min");
        check_rr(3'd4, 1'b0, 1, 2, "xor");
        check_rr(3'd5, 1'b0, 3, 5, "srl");
        check_rr(3'd5, 1'b1, 3, 5, "sra");
        check_rr(3'd6, 1'b0, 1, 2, "or");
        check_rr(3'd7, 1'b0, 1, 2, "and");
        check_ri(3'd0, 1, 12'($random(seed)), "addi");
        check_ri(3'd2, 3, 12'h7ff, "slti min");
        check_ri(3'd2, 4, 12'h800, "slti max");
        check_ri(3'd3, 4, 12'hfff, "sltiu");
        check_ri(3'd4, 1, 12'($random(seed)), "xori");
        check_ri(3'd6, 1, 12'($random(seed)), "ori");
        check_ri(3'd7, 1, 12'($random(seed)), "andi");
        check_ri(3'd1, 2, {7'h00, 5'($random(seed))}, "slli");
        check_ri(3'd5, 3, {7'h00, 5'($random(seed))}, "srli");
        check_ri(3'd5, 3, {7'h20, 5'($random(seed))}, "srai");
        emit({12'h200, 5'd0, 3'b010, 5'd8, 7'b0000011});  // lw x8 of the add result
        regs[8] = exp_data[128];
        store(8, "lw reload", 1'b1);
        upper = 20'($random(seed));
        emit({upper, 5'd9, 7'b0110111});
        regs[9] = {upper, 12'b0};
        store(9, "lui", 1'b1);
        upper = 20'($random(seed));
        regs[9] = {upper, 12'b0} + pc;
        emit({upper, 5'd9, 7'b0010111});
        store(9, "auipc", 1'b1);
        check_branch(3'd0, 1, 1, "beq");
        check_branch(3'd0, 1, 2, "beq");
        check_branch(3'd1, 1, 2, "bne");
        check_branch(3'd1, 1, 1, "bne");
        check_branch(3'd4, 3, 4, "blt");
        check_branch(3'd4, 4, 3, "blt");
        check_branch(3'd5, 4, 3, "bge");
        check_branch(3'd5, 3, 4, "bge");
        check_branch(3'd6, 4, 3, "bltu");
        check_branch(3'd6, 3, 4, "bltu");
        check_branch(3'd7, 3, 4, "bgeu");
        check_branch(3'd7, 4, 3, "bgeu");
        regs[11] = pc + 32'd4;
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd11, 7'b1101111});  // jal x11, +8
        store(10, "jal marker", 1'b0);
        store(11, "jal link", 1'b1);
        load_imm(13, pc + 32'd12);   // jalr x12, 4(x13) lands on the link store
        regs[12] = pc + 32'd4;
        emit({12'd4, 5'd13, 3'b000, 5'd12, 7'b1100111});
        store(10, "jalr marker", 1'b0);
        store(12, "jalr link", 1'b1);
        emit(32'h0010_0073);   // ebreak
    endtask

    task automatic run_program(input string run);
        int cycles;
        cycles = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_req.read && cycles < 4);
        assert (mem_req.read) else begin
            $display("%s: no instruction fetch after reset", run);
            check_errs++;
        end
        assert (!mem_req.read || mem_req.addr == reset_pc) else begin
            $display("ERR %s first fetch expected %h actual %h", run, reset_pc, mem_req.addr);
            check_errs++;
        end
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted) else begin
            $display("%s: the core never halted", run);
            check_errs++;
        end
        repeat (8) @(negedge clk);   // halted core stays off the bus
    endtask

    initial begin : main_flow
        int total;
        seed = 84;
        assemble_main();
        run_program("main program");
        assert (!illegal) else begin
            $display("illegal set after the main program");
            check_errs++;
        end
        assert (n_seen == n_expected) else begin
            $display("only %0d of %0d expected stores reached memory", n_seen, n_expected);
            check_errs++;
        end
        @(posedge clk);
        rst_n <= 1'b0;
        fill_image();
        image[0] = 32'h0000_000f;   // fence is not supported
        run_program("illegal opcode");
        assert (illegal) else begin
            $display("illegal not set after an unsupported opcode");
            check_errs++;
        end
        total = value_errs + monitor_errs + check_errs +
                tinyqv_top_inst.tinyqv_chk_inst.fail_count;
        $display("errors: %0d wrong store values, %0d monitor, %0d other, %0d bound assertions",
                 value_errs, monitor_errs, check_errs,
                 tinyqv_top_inst.tinyqv_chk_inst.fail_count);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tinyqv_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_chk (
    input wire                       clk,
    input wire                       rst_n,
    input wire tinyqv_pkg::mem_req_t mem_req,
    input wire                       fetch_gnt,
    input wire                       data_gnt,
    input wire                       halted
);
    import tinyqv_pkg::*;

    int fail_count = 0;   // read by the testbench summary

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write))
    else begin
        fail_count++;
        $error("read and write strobes high together");
    end

    // the cycle after a read is the data return slot
    no_grant_in_return_slot: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.read |=> !(fetch_gnt || data_gnt))
    else begin
        fail_count++;
        $error("grant given while a read is outstanding");
    end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !$rose(mem_req.read) && !$rose(mem_req.write))
    else begin
        fail_count++;
        $error("bus strobe rose after halt");
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
    else begin
        fail_count++;
        $error("halted dropped without reset");
    end

endmodule

bind tinyqv_top tinyqv_chk tinyqv_chk_inst (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req),
    .fetch_gnt(fetch_gnt), .data_gnt(data_gnt), .halted(halted)
);

`default_nettype wire

/* rtl/tinyqv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_alu (
    input  wire tinyqv_pkg::alu_op_t op,
    input  wire [31:0]               a,
    input  wire [31:0]               b,
    output logic [31:0]              result,
    output logic                     cmp
);
    import tinyqv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_sll:  result = a << shamt;
            op_slt:  result = {31'b0, $signed(a) < $signed(b)};
            op_sltu: result = {31'b0, a < b};
            op_xor:  result = a ^ b;
            op_srl:  result = a >> shamt;
            op_sra:  result = $signed(a) >>> shamt;
            op_or:   result = a | b;
            op_and:  result = a & b;
            default: result = a + b;
        endcase
    end

    // equality for beq/bne, less-than for the other four
    assign cmp = (op == op_xor) ? (result == 32'b0) : result[0];

endmodule

`default_nettype wire

/* rtl/tinyqv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_core (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [31:0]           instr,
    input  wire [31:0]           instr_pc,
    input  wire                  instr_valid,
    output logic                 instr_take,
    output logic                 redirect,
    output logic [31:0]          redirect_pc,
    output tinyqv_pkg::mem_req_t data_req,
    input  wire                  data_gnt,
    input  wire                  data_rvalid,
    input  wire [31:0]           rdata,
    output logic                 halted,
    output logic                 illegal
);
    import tinyqv_pkg::*;

    core_state_t              state;
    logic [31:0]              ir;
    logic [31:0]              pc;
    logic [31:0]              imm;
    logic                     is_load, is_alu_imm, is_auipc, is_store, is_alu_reg;
    logic                     is_lui, is_branch, is_jalr, is_jal, is_system;
    logic [2:1]               instr_len;
    alu_op_t                  alu_op;
    logic [2:0]               mem_op;
    logic [reg_addr_bits-1:0] rs1, rs2, rd;
    logic [31:0]              rs1_data, rs2_data, wr_data;
    logic [31:0]              alu_a, alu_b, alu_result;
    logic                     alu_cmp, wr_en, is_ebreak, legal, taken;

    tinyqv_decoder tinyqv_decoder_inst (
        .instr(ir), .imm(imm),
        .is_load(is_load), .is_alu_imm(is_alu_imm), .is_auipc(is_auipc),
        .is_store(is_store), .is_alu_reg(is_alu_reg), .is_lui(is_lui),
        .is_branch(is_branch), .is_jalr(is_jalr), .is_jal(is_jal),
        .is_system(is_system), .instr_len(instr_len), .alu_op(alu_op),
        .mem_op(mem_op), .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    tinyqv_regfile tinyqv_regfile_inst (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wr_en(wr_en), .wr_data(wr_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_a = (is_auipc || is_jal) ? pc : rs1_data;
    assign alu_b = (is_alu_reg || is_branch) ? rs2_data : imm;

    tinyqv_alu tinyqv_alu_inst (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .cmp(alu_cmp)
    );

    assign is_ebreak = is_system && (ir[31:7] == 25'h0002000);
    assign legal     = (instr_len == 2'b10) &&
                       (is_load || is_store || is_alu_imm || is_alu_reg || is_lui ||
                        is_auipc || is_branch || is_jal || is_jalr || is_ebreak);
    assign taken     = alu_cmp ^ mem_op[0];  // bit 0 flips bne, bge, bgeu

    assign instr_take  = (state == st_wait_instr) && instr_valid;
    assign redirect    = (state == st_exec) && legal && (is_jal || is_jalr || (is_branch && taken));
    assign redirect_pc = (is_jal || is_jalr) ? {alu_result[31:1], 1'b0} : pc + imm;
    assign halted      = (state == st_halt);

    always_comb begin
        data_req.addr  = {alu_result[31:2], 2'b00};  // rs1 + imm, word only
        data_req.wdata = rs2_data;
        data_req.read  = (state == st_mem) && is_load;
        data_req.write = (state == st_mem) && is_store;
    end

    assign wr_en = ((state == st_exec) && legal &&
                    (is_alu_imm || is_alu_reg || is_lui || is_auipc || is_jal || is_jalr)) ||
                   ((state == st_load_wb) && data_rvalid);

    always_comb begin
        if (state == st_load_wb)     wr_data = rdata;
        else if (is_lui)             wr_data = imm;
        else if (is_jal || is_jalr)  wr_data = pc + 32'd4;   // link address
        else                         wr_data = alu_result;
    end

    always_ff @(posedge clk) begin
        if (instr_take) begin
            ir <= instr;
            pc <= instr_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_wait_instr;
            illegal <= 1'b0;
        end else begin
            case (state)
                st_wait_instr: if (instr_valid) state <= st_exec;
                st_exec: begin
                    if (!legal) begin
                        illegal <= 1'b1;
                        state   <= st_halt;
                    end else if (is_ebreak) begin
                        state <= st_halt;
                    end else if (is_load || is_store) begin
                        state <= st_mem;
                    end else begin
                        state <= st_wait_instr;
                    end
                end
                st_mem:     if (data_gnt) state <= is_load ? st_load_wb : st_wait_instr;
                st_load_wb: if (data_rvalid) state <= st_wait_instr;
                default:    state <= st_halt;   // sticky until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/tinyqv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_decoder (
    input  wire [31:0]                            instr,

    output logic [31:0]                           imm,

    output logic                                  is_load,
    output logic                                  is_alu_imm,
    output logic                                  is_auipc,
    output logic                                  is_store,
    output logic                                  is_alu_reg,
    output logic                                  is_lui,
    output logic                                  is_branch,
    output logic                                  is_jalr,
    output logic                                  is_jal,
    output logic                                  is_system,

    output logic [2:1]                            instr_len,
    output tinyqv_pkg::alu_op_t                   alu_op,
    output logic [2:0]                            mem_op,   // bit 0 reverses a branch

    output logic [tinyqv_pkg::reg_addr_bits-1:0]  rs1,
    output logic [tinyqv_pkg::reg_addr_bits-1:0]  rs2,
    output logic [tinyqv_pkg::reg_addr_bits-1:0]  rd
);
    import tinyqv_pkg::*;

    logic [31:0] u_imm;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;

    assign u_imm = {instr[31:12], 12'b0};
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // major opcode classes
    assign is_load    = (instr[6:2] == 5'b00000);
    assign is_alu_imm = (instr[6:2] == 5'b00100);
    assign is_auipc   = (instr[6:2] == 5'b00101);
    assign is_store   = (instr[6:2] == 5'b01000);
    assign is_alu_reg = (instr[6:2] == 5'b01100);
    assign is_lui     = (instr[6:2] == 5'b01101);
    assign is_branch  = (instr[6:2] == 5'b11000);
    assign is_jalr    = (instr[6:2] == 5'b11001);
    assign is_jal     = (instr[6:2] == 5'b11011);
    assign is_system  = (instr[6:2] == 5'b11100);

    always_comb begin
        if (is_auipc || is_lui) imm = u_imm;
        else if (is_store)      imm = s_imm;
        else if (is_branch)     imm = b_imm;
        else if (is_jal)        imm = j_imm;
        else                    imm = i_imm;
    end

    assign instr_len = (instr[1:0] == 2'b11) ? 2'b10 : 2'b01;  // in halfwords

    always_comb begin
        if (is_load || is_auipc || is_store || is_jalr || is_jal) begin
            alu_op = op_add;                                   // address or target
        end else if (is_branch) begin
            alu_op = alu_op_t'({1'b0, ~instr[14], instr[14:13]});  // xor, slt or sltu
        end else if (instr[14:12] == 3'b101) begin
            alu_op = instr[30] ? op_sra : op_srl;
        end else if (instr[14:12] == 3'b000 && is_alu_reg && instr[30]) begin
            alu_op = op_sub;
        end else begin
            alu_op = alu_op_t'({1'b0, instr[14:12]});
        end
    end

    assign mem_op = instr[14:12];

    assign rs1 = instr[15 +: reg_addr_bits];
    assign rs2 = instr[20 +: reg_addr_bits];
    assign rd  = instr[7 +: reg_addr_bits];

endmodule

`default_nettype wire

/* rtl/tinyqv_mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_mem_arbiter (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire tinyqv_pkg::mem_req_t fetch_req,
    input  wire tinyqv_pkg::mem_req_t data_req,
    output logic                 fetch_gnt,
    output logic                 data_gnt,
    output logic                 fetch_rvalid,
    output logic                 data_rvalid,
    output tinyqv_pkg::mem_req_t mem_req
);
    import tinyqv_pkg::*;

    logic       pending;     // read issued last cycle, data on the bus now
    bus_owner_t pend_owner;
    logic       data_wants;

    assign data_wants = data_req.read || data_req.write;

    // data side always wins, nobody wins while the return slot is busy
    assign data_gnt  = !pending && data_wants;
    assign fetch_gnt = !pending && !data_wants && fetch_req.read;

    always_comb begin
        if (data_gnt) begin
            mem_req = data_req;
        end else if (fetch_gnt) begin
            mem_req = fetch_req;
        end else begin
            mem_req = '0;    // idle bus, both strobes low
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            pend_owner <= own_fetch;
        end else begin
            pending <= mem_req.read;
            if (mem_req.read) begin
                pend_owner <= data_gnt ? own_data : own_fetch;
            end
        end
    end

    assign fetch_rvalid = pending && (pend_owner == own_fetch);
    assign data_rvalid  = pending && (pend_owner == own_data);

endmodule

`default_nettype wire

/* rtl/tinyqv_pkg.sv */
`default_nettype none

package tinyqv_pkg;

    localparam int          reg_addr_bits = 4;      // 16 registers, RV32E
    localparam logic [31:0] reset_pc      = 32'h0;  // first fetch address

    // one request on the shared memory bus
    typedef struct packed {
        logic [31:0] addr;   // byte address, word aligned
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } mem_req_t;

    // sub/arith bit on top, funct3 below
    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_sll  = 4'b0001,
        op_slt  = 4'b0010,
        op_sltu = 4'b0011,
        op_xor  = 4'b0100,
        op_srl  = 4'b0101,
        op_or   = 4'b0110,
        op_and  = 4'b0111,
        op_sub  = 4'b1000,
        op_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        st_wait_instr,
        st_exec,
        st_mem,
        st_load_wb,
        st_halt
    } core_state_t;

    typedef enum logic [1:0] {
        f_idle,
        f_req,
        f_wait,
        f_full
    } fetch_state_t;

    typedef enum logic {
        own_fetch,
        own_data
    } bus_owner_t;

endpackage

`default_nettype wire

/* rtl/tinyqv_prefetch.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_prefetch (
    input  wire                  clk,
    input  wire                  rst_n,
    output tinyqv_pkg::mem_req_t fetch_req,
    input  wire                  fetch_gnt,
    input  wire                  fetch_rvalid,
    input  wire [31:0]           rdata,
    output logic [31:0]          instr,
    output logic [31:0]          instr_pc,
    output logic                 instr_valid,
    input  wire                  instr_take,
    input  wire                  redirect,
    input  wire [31:0]           redirect_pc
);
    import tinyqv_pkg::*;

    fetch_state_t state;
    logic [31:0]  fetch_addr;   // word requested, then the word held
    logic [31:0]  buf_word;
    logic         stale;        // in-flight response belongs to an old path

    always_comb begin
        fetch_req.addr  = fetch_addr;
        fetch_req.wdata = 32'b0;
        fetch_req.read  = (state == f_req);
        fetch_req.write = 1'b0;
    end

    assign instr       = buf_word;
    assign instr_pc    = fetch_addr;
    assign instr_valid = (state == f_full);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= f_idle;
            fetch_addr <= reset_pc;
            stale      <= 1'b0;
        end else if (redirect) begin
            fetch_addr <= redirect_pc;
            if ((state == f_req && fetch_gnt) || (state == f_wait && !fetch_rvalid)) begin
                state <= f_wait;                  // let the old word come back and drop it
                stale <= 1'b1;
            end else begin
                state <= f_req;
                stale <= 1'b0;
            end
        end else begin
            case (state)
                f_idle: state <= f_req;
                f_req:  if (fetch_gnt) state <= f_wait;
                f_wait: begin
                    if (fetch_rvalid) begin
                        stale <= 1'b0;
                        state <= stale ? f_req : f_full;  // refetch after a flush
                    end
                end
                f_full: begin
                    if (instr_take) begin
                        fetch_addr <= fetch_addr + 32'd4;   // next word straight away
                        state      <= f_req;
                    end
                end
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_wait && fetch_rvalid && !stale) begin
            buf_word <= rdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/tinyqv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_regfile (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [tinyqv_pkg::reg_addr_bits-1:0]  rs1,
    input  wire [tinyqv_pkg::reg_addr_bits-1:0]  rs2,
    input  wire [tinyqv_pkg::reg_addr_bits-1:0]  rd,
    input  wire                                  wr_en,
    input  wire [31:0]                           wr_data,
    output logic [31:0]                          rs1_data,
    output logic [31:0]                          rs2_data
);
    import tinyqv_pkg::*;

    logic [31:0] regs [1:(2**reg_addr_bits)-1];  // x0 is not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**reg_addr_bits; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? 32'b0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/tinyqv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tinyqv_top (
    input  wire                  clk,
    input  wire                  rst_n,
    output tinyqv_pkg::mem_req_t mem_req,
    input  wire [31:0]           mem_rdata,
    output logic                 halted,
    output logic                 illegal
);
    import tinyqv_pkg::*;

    mem_req_t    fetch_req;
    mem_req_t    data_req;
    logic        fetch_gnt, data_gnt;
    logic        fetch_rvalid, data_rvalid;
    logic [31:0] instr, instr_pc, redirect_pc;
    logic        instr_valid, instr_take, redirect;

    tinyqv_core tinyqv_core_inst (
        .clk(clk), .rst_n(rst_n),
        .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
        .instr_take(instr_take), .redirect(redirect), .redirect_pc(redirect_pc),
        .data_req(data_req), .data_gnt(data_gnt), .data_rvalid(data_rvalid),
        .rdata(mem_rdata), .halted(halted), .illegal(illegal)
    );

    tinyqv_prefetch tinyqv_prefetch_inst (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .fetch_gnt(fetch_gnt), .fetch_rvalid(fetch_rvalid),
        .rdata(mem_rdata),
        .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
        .instr_take(instr_take), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    tinyqv_mem_arbiter tinyqv_mem_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .data_req(data_req),
        .fetch_gnt(fetch_gnt), .data_gnt(data_gnt),
        .fetch_rvalid(fetch_rvalid), .data_rvalid(data_rvalid),
        .mem_req(mem_req)
    );

endmodule

`default_nettype wire
